//--- verilog/speech_pkg.sv
// Speech board shared definitions
// widths, phrase length, tick ratio and the phrase data file

package speech_pkg;

    // allophone code as taken by the synthesizer core
    localparam int ALLO_W = 6;

    // number of codes in the stored phrase
    localparam int PHRASE_LEN = 48;

    // phrase address, wide enough for PHRASE_LEN entries
    localparam int ADDR_W = 6;

    // CLOCK_50 cycles per synthesizer tick (50 MHz / 2.5 MHz)
    localparam int TICK_DIV = 20;

    // segments per seven-segment digit
    localparam int SEG_W = 7;

    // phrase contents, one hex code per line
    localparam string ROM_FILE = "verilog/allophones.hex";

    typedef logic [ALLO_W-1:0] allophone_t;

    typedef logic [ADDR_W-1:0] phrase_addr_t;

    // bit 0 is segment a, a lit segment is 0
    typedef logic [SEG_W-1:0] seg_t;

endpackage

//--- verilog/speech_tick_gen.sv
// Speech tick generator
// one-cycle 2.5 MHz enable derived from CLOCK_50

`timescale 1ns/1ps

module speech_tick_gen (
    input  logic CLOCK_50,
    input  logic rst_n,
    output logic tick
);

    import speech_pkg::*;

    localparam int CNT_W = $clog2(TICK_DIV);

    logic [CNT_W-1:0] cnt;

    // down-counter, tick is registered so the first one lands TICK_DIV cycles after reset
    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
        begin
            cnt  <= CNT_W'(TICK_DIV - 1);
            tick <= 1'b0;
        end
        else
        begin
            tick <= (cnt == '0);
            if (cnt == '0)
                cnt <= CNT_W'(TICK_DIV - 1);
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- verilog/allophone_rom.sv
// Allophone phrase ROM
// synchronous read, contents loaded from the phrase data file

`timescale 1ns/1ps

module allophone_rom (
    input  logic                    CLOCK_50,
    input  speech_pkg::phrase_addr_t rom_addr,
    output speech_pkg::allophone_t   rom_code
);

    import speech_pkg::*;

    allophone_t mem [PHRASE_LEN];

    initial
    begin
        $readmemh(ROM_FILE, mem);
    end

    // read every cycle, one cycle of latency
    always_ff @(posedge CLOCK_50)
    begin
        rom_code <= mem[rom_addr];
    end

endmodule

//--- verilog/phrase_sequencer.sv
// Phrase sequencer
// hands the next allophone to the synthesizer once per load request

`timescale 1ns/1ps

module phrase_sequencer (
    input  logic                     CLOCK_50,
    input  logic                     rst_n,
    input  logic                     tick,
    input  logic                     ldq,
    input  speech_pkg::allophone_t   rom_code,
    output speech_pkg::phrase_addr_t rom_addr,
    output logic                     data_stb,
    output speech_pkg::allophone_t   allophone
);

    import speech_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_LOAD = 2'd1,
        S_WAIT = 2'd2
    } state_t;

    localparam phrase_addr_t LAST_ADDR = phrase_addr_t'(PHRASE_LEN - 1);

    state_t       state;
    state_t       state_nxt;
    phrase_addr_t addr;

    // next state, evaluated only on tick cycles
    always_comb
    begin
        state_nxt = state;
        if (tick)
        begin
            case (state)
                S_IDLE:
                begin
                    if (ldq)
                        state_nxt = S_LOAD;
                end
                S_LOAD:
                begin
                    state_nxt = S_WAIT;
                end
                S_WAIT:
                begin
                    // synthesizer took the code and is busy
                    if (!ldq)
                        state_nxt = S_IDLE;
                end
                default:
                begin
                    state_nxt = S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    // address steps once per strobe and wraps to replay the phrase
    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
        begin
            addr <= '0;
        end
        else if (data_stb)
        begin
            if (addr == LAST_ADDR)
                addr <= '0;
            else
                addr <= addr + 1'b1;
        end
    end

    // addr has been stable for several ticks, so rom_code is already valid here
    assign data_stb  = tick && (state == S_LOAD);
    assign allophone = rom_code;
    assign rom_addr  = addr;

endmodule

//--- verilog/hex_display.sv
// Allophone hex display
// holds the last strobed code and drives two seven-segment digits

`timescale 1ns/1ps

module hex_display (
    input  logic                   CLOCK_50,
    input  logic                   rst_n,
    input  logic                   data_stb,
    input  speech_pkg::allophone_t allophone,
    output speech_pkg::seg_t       hex_lo,
    output speech_pkg::seg_t       hex_hi
);

    import speech_pkg::*;

    allophone_t code;

    // active-low patterns, segment a in bit 0
    function automatic seg_t hex_to_seg(input logic [3:0] digit);
        case (digit)
            4'h0:    hex_to_seg = 7'b1000000;
            4'h1:    hex_to_seg = 7'b1111001;
            4'h2:    hex_to_seg = 7'b0100100;
            4'h3:    hex_to_seg = 7'b0110000;
            4'h4:    hex_to_seg = 7'b0011001;
            4'h5:    hex_to_seg = 7'b0010010;
            4'h6:    hex_to_seg = 7'b0000010;
            4'h7:    hex_to_seg = 7'b1111000;
            4'h8:    hex_to_seg = 7'b0000000;
            4'h9:    hex_to_seg = 7'b0010000;
            4'hA:    hex_to_seg = 7'b0001000;
            4'hB:    hex_to_seg = 7'b0000011;
            4'hC:    hex_to_seg = 7'b1000110;
            4'hD:    hex_to_seg = 7'b0100001;
            4'hE:    hex_to_seg = 7'b0000110;
            default: hex_to_seg = 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
            code <= '0;
        else if (data_stb)
            code <= allophone;
    end

    assign hex_lo = hex_to_seg(code[3:0]);
    // upper digit only ever shows 0..3
    assign hex_hi = hex_to_seg({2'b00, code[ALLO_W-1:4]});

endmodule

//--- verilog/speech_board_top.sv
// Speech board top level
// tick generator, phrase sequencer with ROM, and allophone display

`timescale 1ns/1ps

module speech_board_top (
    input  logic                   CLOCK_50,
    input  logic                   rst_n,
    input  logic                   ldq,
    output logic                   data_stb,
    output speech_pkg::allophone_t allophone,
    output speech_pkg::seg_t       hex_lo,
    output speech_pkg::seg_t       hex_hi
);

    import speech_pkg::*;

    logic         tick;
    phrase_addr_t rom_addr;
    allophone_t   rom_code;

    // 2.5 MHz enable for the sequencer
    speech_tick_gen u_tick_gen (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .tick     (tick)
    );

    allophone_rom u_rom (
        .CLOCK_50 (CLOCK_50),
        .rom_addr (rom_addr),
        .rom_code (rom_code)
    );

    phrase_sequencer u_sequencer (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .tick      (tick),
        .ldq       (ldq),
        .rom_code  (rom_code),
        .rom_addr  (rom_addr),
        .data_stb  (data_stb),
        .allophone (allophone)
    );

    // shows each code handed to the synthesizer
    hex_display u_display (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .data_stb  (data_stb),
        .allophone (allophone),
        .hex_lo    (hex_lo),
        .hex_hi    (hex_hi)
    );

endmodule

//--- tests/speech_board_tb.sv
// Speech board testbench
// synthesizer model on ldq, reference phrase model and assertion checks

`timescale 1ns/1ps

module speech_board_tb;

    import speech_pkg::*;

    localparam int NUM_STROBES    = 110;
    localparam int TIMEOUT_CYCLES = NUM_STROBES * (3 * TICK_DIV + 340) * 2;
    // a seen low gives a strobe within two ticks, so this much silence means a missed low
    localparam int RETRY_CYCLES   = 4 * TICK_DIV;
    localparam logic [31:0] SEED  = 32'h7bda_9873;

    // active-low digit patterns 0..F with segment a in bit 0
    localparam seg_t SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic       CLOCK_50 = 1'b0;
    logic       rst_n;
    logic       ldq;
    logic       data_stb;
    allophone_t allophone;
    seg_t       hex_lo;
    seg_t       hex_hi;

    allophone_t exp_mem [PHRASE_LEN];

    int         cycle_cnt   = 0;
    int         rel_idx     = 0;
    int         stb_count   = 0;
    int         error_count = 0;
    int         exp_addr    = 0;
    int         wait_cnt    = 0;
    int         low_run     = 0;
    allophone_t exp_disp    = '0;
    bit         prev_stb    = 1'b0;
    // set while the sequencer is back in IDLE, as it is after reset
    bit         armed       = 1'b1;
    bit         timed_out   = 1'b0;

    speech_board_top i_dut (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .ldq       (ldq),
        .data_stb  (data_stb),
        .allophone (allophone),
        .hex_lo    (hex_lo),
        .hex_hi    (hex_hi)
    );

    always #5 CLOCK_50 = ~CLOCK_50;

    initial
    begin
        $readmemh(ROM_FILE, exp_mem);
    end

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        error_count++;
        $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic rule_error(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // synthesizer model that takes a code, speaks for a while and asks again
    task automatic drive_ldq();
        int hold;
        int low;
        int waited;
        bit got_stb;
        forever
        begin
            got_stb = 1'b0;
            waited  = 0;
            while (!got_stb && waited < RETRY_CYCLES)
            begin
                @(negedge CLOCK_50);
                got_stb = data_stb;
                waited++;
            end
            if (got_stb)
            begin
                hold = $urandom_range(40, 1);
                repeat (hold) @(negedge CLOCK_50);
            end
            ldq = 1'b0;
            // one low in four is shorter than a tick and may fall between ticks
            if ($urandom_range(3, 0) == 0)
                low = $urandom_range(TICK_DIV - 1, 0);
            else
                low = $urandom_range(300, 0);
            repeat (low) @(negedge CLOCK_50);
            ldq = 1'b1;
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        wait (rst_n === 1'b1);
        drive_ldq();
    end

    // all checks sample on the rising edge before the DUT's flops update
    always @(posedge CLOCK_50)
    begin
        cycle_cnt++;
        if (rst_n)
        begin
            assert (hex_lo == SEG_TABLE[exp_disp[3:0]])
            else value_error("hex_lo", 32'(SEG_TABLE[exp_disp[3:0]]), 32'(hex_lo));
            assert (hex_hi == SEG_TABLE[{2'b00, exp_disp[ALLO_W-1:4]}])
            else value_error("hex_hi", 32'(SEG_TABLE[{2'b00, exp_disp[ALLO_W-1:4]}]),
                             32'(hex_hi));
            assert (!(prev_stb && data_stb))
            else rule_error("data_stb was high for two cycles in a row");

            if (data_stb)
            begin
                assert (rel_idx % TICK_DIV == 0)
                else rule_error("strobe came off the tick grid");
                assert (armed)
                else rule_error("second strobe without a low ldq seen on a tick");
                assert (!(!ldq && low_run > TICK_DIV))
                else rule_error("strobe while ldq had been low for more than a tick");
                assert (allophone == exp_mem[exp_addr])
                else value_error("allophone", 32'(exp_mem[exp_addr]), 32'(allophone));
                exp_disp = exp_mem[exp_addr];
                exp_addr = (exp_addr + 1) % PHRASE_LEN;
                stb_count++;
                armed    = 1'b0;
                wait_cnt = 0;
                low_run  = 0;
            end
            else
            begin
                if (rel_idx > 0 && rel_idx % TICK_DIV == 0 && !ldq)
                    armed = 1'b1;
                if (armed && ldq)
                    wait_cnt++;
                else
                    wait_cnt = 0;
                assert (wait_cnt <= 2 * TICK_DIV)
                else rule_error("ldq stayed high for two ticks without a strobe");
                if (!ldq)
                    low_run++;
                else
                    low_run = 0;
            end

            prev_stb = data_stb;
            rel_idx++;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        ldq   = 1'b1;
        repeat (5) @(negedge CLOCK_50);
        rst_n = 1'b1;

        while (stb_count < NUM_STROBES && cycle_cnt < TIMEOUT_CYCLES)
            @(negedge CLOCK_50);
        // let the display catch up with the last strobe
        repeat (2) @(negedge CLOCK_50);

        if (stb_count < NUM_STROBES)
        begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d strobes arrived within %0d cycles",
                     stb_count, NUM_STROBES, TIMEOUT_CYCLES);
        end
        $display("errors %0d, strobes %0d, cycles %0d", error_count, stb_count, cycle_cnt);
        if (error_count == 0 && !timed_out)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/allophones.hex
// one allophone code per line, two hex digits, 6 bits used
// line order is the phrase address, starting at 0
1B
07
2D
35
03
2E
33
2D
15
02
37
37
1A
0B
03
09
13
0C
29
0A
11
0D
07
2B
04
18
0A
1F
39
3A
2C
0E
13
02
21
17
3E
20
24
3F
10
1D
00
31
26
28
14
04

//--- list.f
verilog/speech_pkg.sv
verilog/speech_tick_gen.sv
verilog/allophone_rom.sv
verilog/phrase_sequencer.sv
verilog/hex_display.sv
verilog/speech_board_top.sv
tests/speech_board_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the speech board testbench with Verilator, runs it and checks the log

set -u

# the ROM data path is relative to the project root
cd "$(dirname "$0")" || exit 1

TOP=speech_board_tb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG_FILE" ]; then
    echo "simulation log is empty"
    exit 1
fi

if grep -q "Testbench failed" "$LOG_FILE"; then
    echo "simulation reported failure, see $LOG_FILE"
    exit 1
fi

exit 0
